// ==== sim.f ====
+incdir+src
src/icache_geom_pkg.sv
src/icache_ctrl_pkg.sv
src/icache_fill_if.sv
src/icache_ram.sv
src/icache_ways.sv
src/icache_beat_counter.sv
src/icache_refill_fsm.sv
src/icache_top.sv
tb/icache_chk.sv
tb/icache_tb.sv

// ==== src/icache_beat_counter.sv ====
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_beat_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear_i,
    input  logic                    beat_i,
    output cache_geom_pkg::offset_t count_o,
    output logic                    last_o
);
    import cache_geom_pkg::*;

    offset_t count_q;

    // word position of the next refill beat
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (beat_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;
    // high during the beat that completes the line
    assign last_o  = beat_i && (count_q == offset_t'(`ICACHE_WORDS - 1));

endmodule

// ==== src/icache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOOKUP  = 3'd1,
        ST_REFILL  = 3'd2,
        ST_SINGLE  = 3'd3,
        ST_RESPOND = 3'd4
    } fsm_state_e;

    // how a request is served
    typedef enum logic {
        REQ_CACHED   = 1'b0,
        REQ_UNCACHED = 1'b1
    } req_kind_e;

endpackage

// ==== src/icache_fill_if.sv ====
`timescale 1ns/10ps

interface icache_fill_if;
    import cache_geom_pkg::*;

    // one beat per cycle with fill_we high
    logic    fill_we;
    index_t  fill_index;
    offset_t fill_offset;
    word_t   fill_data;
    // final beat of the line
    logic    fill_last;

    modport fsm (
        output fill_we,
        output fill_index,
        output fill_offset,
        output fill_data,
        output fill_last
    );

    modport ways (
        input fill_we,
        input fill_index,
        input fill_offset,
        input fill_data,
        input fill_last
    );

endinterface

// ==== src/icache_geom_pkg.sv ====
`include "icache_settings.svh"

package cache_geom_pkg;

    localparam int ADDR_W = `ICACHE_ADDR_W;
    localparam int BYTE_W = 2;
    localparam int OFF_W  = $clog2(`ICACHE_WORDS);
    localparam int IDX_W  = $clog2(`ICACHE_SETS);
    localparam int TAG_W  = ADDR_W - IDX_W - OFF_W - BYTE_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0]       word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [IDX_W-1:0]  index_t;
    typedef logic [OFF_W-1:0]  offset_t;
    typedef logic              way_t;

    typedef struct packed {
        tag_t tag;
    } tag_entry_t;

    // address layout is tag | index | word offset | byte offset
    function automatic tag_t addr_tag(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[BYTE_W+OFF_W +: IDX_W];
    endfunction

    function automatic offset_t addr_offset(addr_t a);
        return a[BYTE_W +: OFF_W];
    endfunction

    function automatic addr_t line_base(addr_t a);
        return {a[ADDR_W-1:BYTE_W+OFF_W], {(BYTE_W+OFF_W){1'b0}}};
    endfunction

endpackage

// ==== src/icache_ram.sv ====
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_ram #(
    parameter type entry_t = cache_geom_pkg::word_t
) (
    input  logic                   clk,
    input  logic                   en_i,
    input  logic                   we_i,
    input  cache_geom_pkg::index_t addr_i,
    input  entry_t                 wdata_i,
    output entry_t                 rdata_o
);

    // one entry per set
    entry_t mem_q [`ICACHE_SETS];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end
            // read-first, old entry shows up on a write cycle
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// ==== src/icache_refill_fsm.sv ====
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_refill_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_i,
    input  cache_geom_pkg::addr_t   addr_i,
    input  logic                    hit_i,
    input  cache_geom_pkg::word_t   hit_data_i,
    input  cache_geom_pkg::offset_t beat_count_i,
    input  logic                    beat_last_i,
    output logic                    beat_clear_o,
    output logic                    mem_req_o,
    output cache_geom_pkg::addr_t   mem_addr_o,
    output logic                    mem_line_o,
    input  logic                    mem_rvalid_i,
    input  cache_geom_pkg::word_t   mem_rdata_i,
    icache_fill_if.fsm              fill,
    output logic                    resp_valid_o,
    output cache_geom_pkg::word_t   rdata_o,
    output logic                    busy_o
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    fsm_state_e state_q;
    fsm_state_e state_d;
    req_kind_e  kind_q;
    req_kind_e  kind_new;
    addr_t      addr_q;
    word_t      data_q;
    logic       lookup_hit;
    logic       lookup_miss;

    // mmu style segment check on the top three bits
    assign kind_new = (addr_i[ADDR_W-1 -: 3] == `ICACHE_UNCACHED_SEG) ?
                      REQ_UNCACHED : REQ_CACHED;

    assign lookup_hit  = (state_q == ST_LOOKUP) && (kind_q == REQ_CACHED) && hit_i;
    assign lookup_miss = (state_q == ST_LOOKUP) && !lookup_hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (lookup_hit) begin
                    state_d = ST_IDLE;
                end else if (kind_q == REQ_UNCACHED) begin
                    state_d = ST_SINGLE;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            // gaps between beats just hold the state
            ST_REFILL: begin
                if (fill.fill_we && beat_last_i) begin
                    state_d = ST_RESPOND;
                end
            end
            ST_SINGLE: begin
                if (mem_rvalid_i) begin
                    state_d = ST_RESPOND;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && req_i) begin
            addr_q <= addr_i;
            kind_q <= kind_new;
        end
        // keep the requested word as it streams past
        if (fill.fill_we && (beat_count_i == addr_offset(addr_q))) begin
            data_q <= mem_rdata_i;
        end
        if ((state_q == ST_SINGLE) && mem_rvalid_i) begin
            data_q <= mem_rdata_i;
        end
    end

    // memory side
    assign mem_req_o    = lookup_miss;
    assign beat_clear_o = lookup_miss;
    assign mem_line_o   = (kind_q == REQ_CACHED);
    assign mem_addr_o   = mem_line_o ? line_base(addr_q) : addr_q;

    // uncached beats never reach the arrays
    assign fill.fill_we     = (state_q == ST_REFILL) && mem_rvalid_i;
    assign fill.fill_index  = addr_index(addr_q);
    assign fill.fill_offset = beat_count_i;
    assign fill.fill_data   = mem_rdata_i;
    assign fill.fill_last   = beat_last_i;

    // core side
    assign resp_valid_o = lookup_hit || (state_q == ST_RESPOND);
    assign rdata_o      = lookup_hit ? hit_data_i : data_q;
    assign busy_o       = (state_q != ST_IDLE);

endmodule

// ==== src/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// byte address width seen by the core and by memory
`define ICACHE_ADDR_W 32

// sets per way, two ways in total
`define ICACHE_SETS 64

// 32-bit words in one cache line
`define ICACHE_WORDS 4

// top three address bits of the uncached segment
// accesses here bypass the arrays and fetch one word
`define ICACHE_UNCACHED_SEG 3'b101

`endif

// ==== src/icache_top.sv ====
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_i,
    input  logic [`ICACHE_ADDR_W-1:0] addr_i,
    input  logic                     flush_i,
    output logic                     resp_valid_o,
    output logic [31:0]              rdata_o,
    output logic                     busy_o,
    output logic                     mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o,
    output logic                     mem_line_o,
    input  logic                     mem_rvalid_i,
    input  logic [31:0]              mem_rdata_i
);
    import cache_geom_pkg::*;

    logic    hit;
    word_t   hit_data;
    offset_t beat_count;
    logic    beat_last;
    logic    beat_clear;

    // refill beats from controller to storage
    icache_fill_if u_fill ();

    icache_ways u_ways (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .addr_i     (addr_i),
        .flush_i    (flush_i),
        .fill       (u_fill.ways),
        .hit_o      (hit),
        .hit_data_o (hit_data)
    );

    // counts only beats that are written into a line
    icache_beat_counter u_beat_counter (
        .clk     (clk),
        .rst     (rst),
        .clear_i (beat_clear),
        .beat_i  (u_fill.fill_we),
        .count_o (beat_count),
        .last_o  (beat_last)
    );

    icache_refill_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .hit_i        (hit),
        .hit_data_i   (hit_data),
        .beat_count_i (beat_count),
        .beat_last_i  (beat_last),
        .beat_clear_o (beat_clear),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_line_o   (mem_line_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .fill         (u_fill.fsm),
        .resp_valid_o (resp_valid_o),
        .rdata_o      (rdata_o),
        .busy_o       (busy_o)
    );

endmodule

// ==== src/icache_ways.sv ====
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_ways (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  cache_geom_pkg::addr_t addr_i,
    input  logic                  flush_i,
    icache_fill_if.ways           fill,
    output logic                  hit_o,
    output cache_geom_pkg::word_t hit_data_o
);
    import cache_geom_pkg::*;

    // per-set state, kept in flops so a flush clears it at once
    logic [1:0][`ICACHE_SETS-1:0] valid_q;
    // lru bit names the way to evict next
    logic [`ICACHE_SETS-1:0]      lru_q;

    // registered lookup
    logic    req_q;
    tag_t    tag_q;
    index_t  idx_q;
    offset_t off_q;
    way_t    victim_q;

    index_t     ram_addr;
    tag_entry_t tag_wr;
    tag_entry_t tag_rd [2];
    word_t      word_rd [2][`ICACHE_WORDS];
    logic [1:0] way_hit;
    logic       first_beat;
    way_t       victim_new;
    way_t       fill_way;

    // fill beats and lookups never overlap
    assign ram_addr   = fill.fill_we ? fill.fill_index : addr_index(addr_i);
    assign first_beat = fill.fill_we && (fill.fill_offset == '0);
    assign tag_wr     = '{tag: tag_q};

    // invalid way first, else follow lru
    always_comb begin
        if (!valid_q[0][fill.fill_index]) begin
            victim_new = 1'b0;
        end else if (!valid_q[1][fill.fill_index]) begin
            victim_new = 1'b1;
        end else begin
            victim_new = lru_q[fill.fill_index];
        end
    end

    assign fill_way = first_beat ? victim_new : victim_q;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic tag_we;

        // tag goes in with the first beat
        assign tag_we = first_beat && (fill_way == way_t'(w));

        icache_ram #(.entry_t(tag_entry_t)) u_tag_ram (
            .clk     (clk),
            .en_i    (req_i || tag_we),
            .we_i    (tag_we),
            .addr_i  (ram_addr),
            .wdata_i (tag_wr),
            .rdata_o (tag_rd[w])
        );

        for (genvar b = 0; b < `ICACHE_WORDS; b++) begin : g_word
            logic word_we;

            assign word_we = fill.fill_we && (fill_way == way_t'(w))
                             && (fill.fill_offset == offset_t'(b));

            icache_ram #(.entry_t(word_t)) u_data_ram (
                .clk     (clk),
                .en_i    (req_i || word_we),
                .we_i    (word_we),
                .addr_i  (ram_addr),
                .wdata_i (fill.fill_data),
                .rdata_o (word_rd[w][b])
            );
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = req_q && valid_q[w][idx_q] && (tag_rd[w].tag == tag_q);
        end
    end

    assign hit_o      = |way_hit;
    // at most one way can match
    assign hit_data_o = word_rd[way_hit[1]][off_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            lru_q   <= '0;
            req_q   <= 1'b0;
        end else begin
            req_q <= req_i;
            if (flush_i) begin
                valid_q <= '0;
                lru_q   <= '0;
            end else begin
                if (hit_o) begin
                    lru_q[idx_q] <= ~way_hit[1];
                end
                if (fill.fill_we && fill.fill_last) begin
                    valid_q[fill_way][fill.fill_index] <= 1'b1;
                    lru_q[fill.fill_index]             <= ~fill_way;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            tag_q <= addr_tag(addr_i);
            idx_q <= addr_index(addr_i);
            off_q <= addr_offset(addr_i);
        end
        if (first_beat) begin
            victim_q <= victim_new;
        end
    end

endmodule

// ==== tb/icache_chk.sv ====
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      req_i,
    input logic [`ICACHE_ADDR_W-1:0] addr_i,
    input logic                      flush_i,
    input logic                      busy_i,
    input logic                      resp_valid_i,
    input logic                      mem_req_i
);

    logic cached_req;
    int   fail_count = 0;

    assign cached_req = req_i && (addr_i[`ICACHE_ADDR_W-1 -: 3] != `ICACHE_UNCACHED_SEG);

    // controller idle right after reset
    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !busy_i)
        else begin
            fail_count++;
            $error("busy_o high in the first cycle after reset");
        end

    strobes_while_busy: assert property (@(posedge clk) disable iff (rst)
        (resp_valid_i || mem_req_i) |-> busy_i)
        else begin
            fail_count++;
            $error("resp_valid_o or mem_req_o while busy_o is low");
        end

    no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        (req_i || flush_i) |-> !busy_i)
        else begin
            fail_count++;
            $error("req_i or flush_i while busy_o is high");
        end

    // hit answers, miss goes to memory, both one cycle later
    lookup_outcome: assert property (@(posedge clk) disable iff (rst)
        cached_req |=> (resp_valid_i || mem_req_i))
        else begin
            fail_count++;
            $error("cached request gave neither a response nor a memory request");
        end

endmodule

bind icache_top icache_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .flush_i      (flush_i),
    .busy_i       (busy_o),
    .resp_valid_i (resp_valid_o),
    .mem_req_i    (mem_req_o)
);

// ==== tb/icache_tb.sv ====
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tb;

    localparam int CLK_NS  = 40;
    localparam int N_FIXED = 18;
    localparam int N_RAND  = 300;
    // worst case cycles for one request, gaps of up to 3 before each beat
    localparam int REQ_CYC = `ICACHE_WORDS * 4 + 4;
    localparam int OFF_LO  = 2;
    localparam int IDX_LO  = OFF_LO + $clog2(`ICACHE_WORDS);
    localparam int TAG_LO  = IDX_LO + $clog2(`ICACHE_SETS);
    localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_i;
    logic [31:0] addr_i;
    logic        flush_i;
    logic        resp_valid_o;
    logic [31:0] rdata_o;
    logic        busy_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic        mem_line_o;
    logic        mem_rvalid_i;
    logic [31:0] mem_rdata_i;

    integer      seed = 32'hb593;
    int          errors = 0;
    int          checks = 0;
    int          mem_reqs = 0;
    logic [31:0] last_mem_addr;
    logic        last_mem_line;
    time         last_beat_at = 0;

    // reference model, two ways per set
    logic [31:0] m_tag [2][`ICACHE_SETS];
    bit          m_valid [2][`ICACHE_SETS];
    bit          m_lru [`ICACHE_SETS];

    icache_top UUT (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .flush_i      (flush_i),
        .resp_valid_o (resp_valid_o),
        .rdata_o      (rdata_o),
        .busy_o       (busy_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_line_o   (mem_line_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ MEM_KEY;
    endfunction

    function automatic bit is_uncached(input logic [31:0] a);
        return a[31:29] == `ICACHE_UNCACHED_SEG;
    endfunction

    // memory answers each strobe with a line or a single word
    initial begin
        int          gap;
        int          beats;
        logic [31:0] base;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(negedge clk);
            if (mem_req_o) begin
                mem_reqs++;
                last_mem_addr = mem_addr_o;
                last_mem_line = mem_line_o;
                base  = mem_addr_o;
                beats = mem_line_o ? `ICACHE_WORDS : 1;
                for (int b = 0; b < beats; b++) begin
                    @(posedge clk);
                    mem_rvalid_i <= 1'b0;
                    gap = $random(seed) & 3;
                    repeat (gap) @(posedge clk);
                    mem_rvalid_i <= 1'b1;
                    mem_rdata_i  <= mem_word(base + 4 * b);
                end
                // the beat just driven is the last one
                last_beat_at = $time;
                @(posedge clk);
                mem_rvalid_i <= 1'b0;
            end
        end
    end

    // updates the model, hit stays low for uncached space
    task automatic model_access(input logic [31:0] a, output bit hit);
        int          idx;
        int          way;
        logic [31:0] tag;
        idx = (a >> IDX_LO) % `ICACHE_SETS;
        tag = a >> TAG_LO;
        hit = 1'b0;
        way = 0;
        if (is_uncached(a)) return;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = !m_valid[0][idx] ? 0 : (!m_valid[1][idx] ? 1 : int'(m_lru[idx]));
            m_valid[way][idx] = 1'b1;
            m_tag[way][idx]   = tag;
        end
        m_lru[idx] = (way == 0);
    endtask

    // called on a rising edge, returns on a rising edge
    task automatic flush_cache();
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
    endtask

    task automatic fetch(input string name, input logic [31:0] a);
        logic [31:0] exp_data;
        logic [31:0] exp_addr;
        bit          exp_hit;
        bit          exp_line;
        int          reqs_before;
        int          cyc;
        exp_data    = mem_word(a);
        exp_line    = !is_uncached(a);
        exp_addr    = exp_line ? {a[31:IDX_LO], {IDX_LO{1'b0}}} : a;
        reqs_before = mem_reqs;
        model_access(a, exp_hit);
        req_i  <= 1'b1;
        addr_i <= a;
        @(posedge clk);
        req_i <= 1'b0;
        cyc = 1;
        @(negedge clk);
        // a miss strobes memory right after the request
        if (mem_req_o !== !exp_hit) begin
            errors++;
            $display("%s: mem_req_o was %b in the cycle after the request for %h",
                     name, mem_req_o, a);
        end
        if (busy_o !== 1'b1) begin
            errors++;
            $display("%s: busy_o low in the cycle after the request for %h", name, a);
        end
        while (!resp_valid_o && cyc < REQ_CYC) begin
            @(negedge clk);
            cyc++;
        end
        checks++;
        if (!resp_valid_o) begin
            errors++;
            $display("%s: no response for address %h within %0d cycles", name, a, REQ_CYC);
        end else if (rdata_o !== exp_data) begin
            errors++;
            $display("MISMATCH %s: rdata at %h expected %h actual %h",
                     name, a, exp_data, rdata_o);
        end
        if (resp_valid_o && !exp_hit && $time != last_beat_at + CLK_NS + CLK_NS / 2) begin
            errors++;
            $display("%s: response for %h did not follow the last memory beat by one cycle",
                     name, a);
        end
        @(posedge clk);
        @(negedge clk);
        // one-cycle response, then the cache is free again
        if (resp_valid_o !== 1'b0 || busy_o !== 1'b0) begin
            errors++;
            $display("%s: resp_valid_o or busy_o still high after the response for %h",
                     name, a);
        end
        if (exp_hit && cyc != 1) begin
            errors++;
            $display("%s: expected a hit at %h but the response took %0d cycles", name, a, cyc);
        end
        if (exp_hit && mem_reqs != reqs_before) begin
            errors++;
            $display("%s: unexpected memory request for address %h", name, a);
        end
        if (!exp_hit && mem_reqs != reqs_before + 1) begin
            errors++;
            $display("%s: expected one memory request for %h, saw %0d",
                     name, a, mem_reqs - reqs_before);
        end else if (!exp_hit) begin
            if (last_mem_addr !== exp_addr) begin
                errors++;
                $display("MISMATCH %s: mem_addr expected %h actual %h",
                         name, exp_addr, last_mem_addr);
            end
            if (last_mem_line !== exp_line) begin
                errors++;
                $display("MISMATCH %s: mem_line expected %b actual %b",
                         name, exp_line, last_mem_line);
            end
        end
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] line_a;
        logic [31:0] line_b;
        logic [31:0] line_c;
        integer      r;
        rst     = 1'b1;
        req_i   = 1'b0;
        addr_i  = '0;
        flush_i = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        fetch("cold_miss", 32'h0000_1230);
        fetch("repeat_hit", 32'h0000_1230);
        for (int w = 0; w < `ICACHE_WORDS; w++) begin
            fetch("line_fill", 32'h0000_1230 + 4 * w);
        end

        // three tags on the same index
        line_a = 32'h0000_2040;
        line_b = line_a + (32'd1 << TAG_LO);
        line_c = line_a + (32'd2 << TAG_LO);
        fetch("lru_fill_a", line_a);
        fetch("lru_fill_b", line_b);
        fetch("lru_touch_a", line_a);
        fetch("lru_evict", line_c);
        fetch("lru_keep_a", line_a);
        fetch("lru_refetch_b", line_b);

        repeat (3) fetch("uncached", 32'hA000_0104);
        fetch("uncached", 32'hBFC0_0008);

        flush_cache();
        fetch("flush_miss", 32'h0000_1230);
        fetch("flush_miss", line_a);

        // few tags over few sets so that lines get evicted often
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                flush_cache();
            end
            a = '0;
            if (r[7:4] < 4'd3) begin
                a = 32'hA000_0000 | {r[15:8], 2'b00};
            end else begin
                a[TAG_LO +: 2] = r[17:16];
                a[IDX_LO +: 2] = r[19:18];
                a[OFF_LO +: 2] = r[21:20];
            end
            fetch("random_mix", a);
        end

        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, UUT.u_chk.fail_count);
        if (errors == 0 && UUT.u_chk.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #((N_FIXED + N_RAND) * REQ_CYC * CLK_NS + 2000 * CLK_NS);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

endmodule
